//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := mem_subsys_tb
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/cache_arbiter.sv
// memory port arbiter between icache and dcache; grants on acq, muxes request and ready
`timescale 1ns/1ps

module cache_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    // icache side
    input  logic                     i_acq_i,
    input  mem_arb_pkg::ifetch_req_t i_req_i,
    output logic                     i_ready_o,
    // dcache side
    input  logic                     d_acq_i,
    input  mem_arb_pkg::mem_req_t    d_req_i,
    output logic                     d_ready_o,
    // memory side
    output mem_arb_pkg::mem_req_t    mem_req_o,
    input  logic                     mem_ready_i
);
    import mem_arb_pkg::*;

    arb_state_e state_q;   // current owner
    arb_state_e state_d;

    // grant register, moves the edge after acq changes
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // dcache wins a tie, owner holds while acq stays high
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (d_acq_i) begin
                    state_d = ARB_DCACHE;
                end else if (i_acq_i) begin
                    state_d = ARB_ICACHE;
                end
            end
            ARB_DCACHE: begin
                if (!d_acq_i) begin
                    state_d = ARB_IDLE;   // one idle cycle before regrant
                end
            end
            ARB_ICACHE: begin
                if (!i_acq_i) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    // request mux and ready routing, purely from grant state
    always_comb begin
        mem_req_o    = '0;
        mem_req_o.op = MEM_READ;
        i_ready_o    = 1'b0;   // non-owner ready stays low
        d_ready_o    = 1'b0;
        case (state_q)
            ARB_DCACHE: begin
                mem_req_o = d_req_i;
                d_ready_o = mem_ready_i;
            end
            ARB_ICACHE: begin
                // widen the fetch into a read request
                mem_req_o.valid = i_req_i.valid;
                mem_req_o.op    = MEM_READ;
                mem_req_o.addr  = i_req_i.addr;
                mem_req_o.wdata = '0;          // no write data on refills
                i_ready_o       = mem_ready_i;
            end
            default: begin
                // idle: valid low, nothing routed back
            end
        endcase
    end

endmodule

//--- source/line_burst_ctrl.sv
// line burst controller; moves one 128-bit line as two 64-bit word RAM beats, then pulses ready
`timescale 1ns/1ps

module line_burst_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    // arbitrated request
    input  mem_arb_pkg::mem_req_t                req_i,
    output logic                                 ready_o,
    output mem_arb_pkg::line_t                   rdata_o,
    // word RAM port
    output logic                                 ram_we_o,
    output logic [mem_arb_pkg::WORD_IDX_W-1:0]   ram_idx_o,
    output mem_arb_pkg::word_t                   ram_wdata_o,
    input  mem_arb_pkg::word_t                   ram_rdata_i
);
    import mem_arb_pkg::*;

    burst_state_e            state_q;
    logic [WAIT_W-1:0]       wait_cnt_q;   // cycles spent in BURST_WAIT
    logic                    beat_q;       // 0 low word, 1 high word

    // latched request payload
    addr_t                   addr_q;
    mem_op_e                 op_q;
    line_t                   wdata_q;
    line_t                   line_q;       // read beats reassembled here

    logic [LINE_IDX_W-1:0]   line_idx;

    // line index sits above the 16-byte offset, wraps at MEM_LINES
    assign line_idx = addr_q[OFFSET_W +: LINE_IDX_W];

    // even word holds the low half, odd word the high half
    assign ram_idx_o   = {line_idx, beat_q};
    assign ram_we_o    = (state_q == BURST_BEAT) && (op_q == MEM_WRITE);
    assign ram_wdata_o = beat_q ? wdata_q[LINE_W-1:WORD_W] : wdata_q[WORD_W-1:0];

    assign ready_o = (state_q == BURST_RESP);   // exactly one cycle
    assign rdata_o = line_q;

    // sequencing: idle, wait, beat, wait, beat, resp
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= BURST_IDLE;
            wait_cnt_q <= '0;
            beat_q     <= 1'b0;
        end else begin
            case (state_q)
                BURST_IDLE: begin
                    if (req_i.valid) begin
                        state_q    <= BURST_WAIT;
                        wait_cnt_q <= '0;
                        beat_q     <= 1'b0;
                    end
                end
                BURST_WAIT: begin
                    if (wait_cnt_q == WAIT_W'(BEAT_WAIT - 1)) begin
                        state_q    <= BURST_BEAT;
                        wait_cnt_q <= '0;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                BURST_BEAT: begin
                    if (beat_q) begin
                        state_q <= BURST_RESP;   // both words done
                    end else begin
                        state_q <= BURST_WAIT;
                        beat_q  <= 1'b1;
                    end
                end
                BURST_RESP: begin
                    state_q <= BURST_IDLE;   // client drops valid on this edge
                end
                default: state_q <= BURST_IDLE;
            endcase
        end
    end

    // request capture on accept
    always_ff @(posedge clk) begin
        if ((state_q == BURST_IDLE) && req_i.valid) begin
            addr_q  <= req_i.addr;
            op_q    <= req_i.op;
            wdata_q <= req_i.wdata;
        end
    end

    // read data capture
    // the index is already stable through the wait cycles, so the RAM word
    // for this beat is on ram_rdata_i one cycle after it was addressed
    always_ff @(posedge clk) begin
        if ((state_q == BURST_BEAT) && (op_q == MEM_READ)) begin
            if (beat_q) begin
                line_q[LINE_W-1:WORD_W] <= ram_rdata_i;   // high half
            end else begin
                line_q[WORD_W-1:0] <= ram_rdata_i;        // low half
            end
        end
    end

endmodule

//--- source/mem_arb_pkg.sv
// shared widths, line/word types, request structs and state enums; imported by all RTL files
package mem_arb_pkg;

    // bus and storage widths
    localparam int ADDR_W    = 64;    // byte address
    localparam int WORD_W    = 64;    // one RAM word, one beat
    localparam int LINE_W    = 128;   // one cache line, two beats
    localparam int MEM_LINES = 128;   // lines held by the word RAM
    localparam int BEAT_WAIT = 2;     // idle cycles before each beat, models latency

    // derived sizes
    localparam int RAM_WORDS  = 2 * MEM_LINES;          // two words per line
    localparam int OFFSET_W   = $clog2(LINE_W / 8);     // byte offset inside a line
    localparam int LINE_IDX_W = $clog2(MEM_LINES);      // line index bits
    localparam int WORD_IDX_W = $clog2(RAM_WORDS);      // line index plus beat bit
    localparam int WAIT_W     = $clog2(BEAT_WAIT + 1);  // wait counter width

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [WORD_W-1:0] word_t;

    // memory operation, icache only ever reads
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // port owner
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'd0,
        ARB_ICACHE = 2'd1,
        ARB_DCACHE = 2'd2
    } arb_state_e;

    // line burst sequencing
    typedef enum logic [1:0] {
        BURST_IDLE = 2'd0,  // waiting for a valid request
        BURST_WAIT = 2'd1,  // latency before a beat
        BURST_BEAT = 2'd2,  // one word moved
        BURST_RESP = 2'd3   // ready pulse with the line
    } burst_state_e;

    // icache refill request, read only so no op or wdata
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ifetch_req_t;

    // dcache request, also the arbitrated request toward memory
    typedef struct packed {
        logic    valid;
        mem_op_e op;
        addr_t   addr;
        line_t   wdata;
    } mem_req_t;

endpackage

//--- source/mem_subsys_top.sv
// memory subsystem top; arbiter, burst controller and word RAM behind the two cache ports
`timescale 1ns/1ps

module mem_subsys_top (
    input  logic                     clk,
    input  logic                     rst,
    // icache refill port
    input  logic                     i_acq_i,
    input  mem_arb_pkg::ifetch_req_t i_req_i,
    output logic                     i_ready_o,
    // dcache refill and writeback port
    input  logic                     d_acq_i,
    input  mem_arb_pkg::mem_req_t    d_req_i,
    output logic                     d_ready_o,
    // line return shared by both caches
    output mem_arb_pkg::line_t       rdata_o
);
    import mem_arb_pkg::*;

    mem_req_t                mem_req;     // granted request
    logic                    mem_ready;   // burst done pulse
    logic                    ram_we;
    logic [WORD_IDX_W-1:0]   ram_idx;
    word_t                   ram_wdata;
    word_t                   ram_rdata;

    cache_arbiter i_cache_arbiter (
        .clk         (clk),
        .rst         (rst),
        .i_acq_i     (i_acq_i),
        .i_req_i     (i_req_i),
        .d_acq_i     (d_acq_i),
        .d_req_i     (d_req_i),
        .i_ready_o   (i_ready_o),
        .d_ready_o   (d_ready_o),
        .mem_req_o   (mem_req),
        .mem_ready_i (mem_ready)
    );

    line_burst_ctrl i_line_burst_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_i       (mem_req),
        .ready_o     (mem_ready),
        .rdata_o     (rdata_o),
        .ram_we_o    (ram_we),
        .ram_idx_o   (ram_idx),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    word_ram i_word_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .idx_i   (ram_idx),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

//--- source/word_ram.sv
// single-port 64-bit word store with registered read; backs the line memory of the subsystem
`timescale 1ns/1ps

module word_ram (
    input  logic                               clk,
    input  logic                               we_i,
    input  logic [mem_arb_pkg::WORD_IDX_W-1:0] idx_i,
    input  mem_arb_pkg::word_t                 wdata_i,
    output mem_arb_pkg::word_t                 rdata_o
);
    import mem_arb_pkg::*;

    word_t mem_q [RAM_WORDS];   // two words per line

    // lines never written read back as zero
    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[idx_i] <= wdata_i;
        end
    end

    // one cycle read latency, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata_o <= mem_q[idx_i];
    end

endmodule

//--- sources.f
source/mem_arb_pkg.sv
source/cache_arbiter.sv
source/line_burst_ctrl.sv
source/word_ram.sv
source/mem_subsys_top.sv
test/mem_subsys_assertions.sv
test/mem_subsys_tb.sv

//--- test/mem_subsys_assertions.sv
// grant and ready properties of the cache arbiter; bound into cache_arbiter by the testbench
`timescale 1ns/1ps

module mem_subsys_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    i_acq_i,
    input logic                    d_acq_i,
    input logic                    i_ready_i,    // arbiter i_ready_o
    input logic                    d_ready_i,    // arbiter d_ready_o
    input mem_arb_pkg::mem_req_t   mem_req_i,    // request toward the burst controller
    input mem_arb_pkg::arb_state_e state_i       // grant register
);
    import mem_arb_pkg::*;

    // a done pulse only ever goes to one port
    one_ready_at_a_time: assert property (
        @(posedge clk) disable iff (rst) !(i_ready_i && d_ready_i)
    ) else $error("i_ready_o and d_ready_o high in the same cycle");

    // icache only gets ready while it holds the port
    i_ready_needs_acq: assert property (
        @(posedge clk) disable iff (rst) i_ready_i |-> i_acq_i
    ) else $error("i_ready_o high while i_acq_i is low");

    d_ready_needs_acq: assert property (
        @(posedge clk) disable iff (rst) d_ready_i |-> d_acq_i
    ) else $error("d_ready_o high while d_acq_i is low");

    // no owner means nothing reaches memory
    idle_no_valid: assert property (
        @(posedge clk) disable iff (rst) (state_i == ARB_IDLE) |-> !mem_req_i.valid
    ) else $error("memory request valid while the arbiter is idle");

endmodule

//--- test/mem_subsys_tb.sv
// testbench for the memory subsystem; replays test/mem_subsys_testdata.txt on both cache ports
`timescale 1ns/1ps

module mem_subsys_tb;
    import mem_arb_pkg::*;

    // one parsed line of the data file
    typedef struct packed {
        logic [7:0] cmd;      // W R I B H
        addr_t      d_addr;
        addr_t      i_addr;
        line_t      wline;
        line_t      exp_d;
        line_t      exp_i;
    } cmd_t;

    localparam int CYCLES_PER_CMD = 100;
    localparam int SETUP_CYCLES   = 16;   // reset plus idle checks

    logic        clk;
    logic        rst;
    logic        i_acq;
    ifetch_req_t i_req;
    logic        i_ready;
    logic        d_acq;
    mem_req_t    d_req;
    logic        d_ready;
    line_t       rdata;

    cmd_t        cmd_q[$];
    arb_state_e  served_q[$];            // port order of observed ready pulses
    line_t       model_q[MEM_LINES];     // scoreboard of line memory
    int          err_cnt     = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;        // armed once the file is loaded

    mem_subsys_top i_mem_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .i_acq_i   (i_acq),
        .i_req_i   (i_req),
        .i_ready_o (i_ready),
        .d_acq_i   (d_acq),
        .d_req_i   (d_req),
        .d_ready_o (d_ready),
        .rdata_o   (rdata)
    );

    bind cache_arbiter mem_subsys_assertions i_mem_subsys_assertions (
        .clk       (clk),
        .rst       (rst),
        .i_acq_i   (i_acq_i),
        .d_acq_i   (d_acq_i),
        .i_ready_i (i_ready_o),
        .d_ready_i (d_ready_o),
        .mem_req_i (mem_req_o),
        .state_i   (state_q)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // run limit scales with the number of commands
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles waiting for a ready pulse", cycle_cnt));
        end
    end

    task automatic abort_run(input string why);
        err_cnt++;
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_grant(input string name, input arb_state_e got, input arb_state_e exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h (%s), expected 0x%h (%s)",
                                name, got, got.name(), exp, exp.name()));
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // byte address to line index modulo MEM_LINES
    function automatic int line_index(input addr_t addr);
        addr_t line_no;
        line_no = addr / addr_t'(LINE_W / 8);
        return int'(line_no % addr_t'(MEM_LINES));
    endfunction

    // the file's expected line has to agree with the scoreboard
    task automatic match_model(input addr_t addr, input line_t file_exp, input int num);
        if (model_q[line_index(addr)] !== file_exp) begin
            abort_run($sformatf("testdata command %0d expects 0x%h at 0x%h but model holds 0x%h",
                                num, file_exp, addr, model_q[line_index(addr)]));
        end
    endtask

    // ready pulses must arrive in the given port order
    task automatic check_service(input arb_state_e exp_order[$]);
        if (served_q.size() != exp_order.size()) begin
            abort_run($sformatf("expected %0d ready pulses but saw %0d",
                                exp_order.size(), served_q.size()));
        end
        foreach (exp_order[k]) begin
            check_grant($sformatf("served port %0d", k), served_q[k], exp_order[k]);
        end
    endtask

    task automatic load_commands();
        int         fd;
        int         n;
        string      text;
        logic [7:0] cmd;
        addr_t      da;
        addr_t      ia;
        line_t      wl;
        line_t      ed;
        line_t      ei;
        cmd_t       c;
        fd = $fopen("test/mem_subsys_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open test/mem_subsys_testdata.txt");
        end
        while (!$feof(fd)) begin
            if ($fgets(text, fd) == 0) begin
                break;
            end
            if (text.len() < 2 || text.getc(0) == "#") begin
                continue;   // blank or comment
            end
            n = $sscanf(text, "%c %h %h %h %h %h", cmd, da, ia, wl, ed, ei);
            if (n != 6) begin
                abort_run($sformatf("malformed testdata line %s", text));
            end
            c.cmd    = cmd;
            c.d_addr = da;
            c.i_addr = ia;
            c.wline  = wl;
            c.exp_d  = ed;
            c.exp_i  = ei;
            cmd_q.push_back(c);
        end
        $fclose(fd);
    endtask

    // one dcache transaction with acq already held
    task automatic dcache_request(input mem_op_e op, input addr_t addr, input line_t wline,
                                  output line_t rline);
        @(posedge clk);
        #1;
        d_req.op    = op;
        d_req.addr  = addr;
        d_req.wdata = wline;
        d_req.valid = 1'b1;   // held until ready
        do begin
            @(posedge clk);
            #1;
        end while (!d_ready);
        rline       = rdata;  // line stable during the pulse
        d_req.valid = 1'b0;
        served_q.push_back(ARB_DCACHE);
    endtask

    task automatic icache_request(input addr_t addr, output line_t rline);
        @(posedge clk);
        #1;
        i_req.addr  = addr;
        i_req.valid = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!i_ready);
        rline       = rdata;
        i_req.valid = 1'b0;
        served_q.push_back(ARB_ICACHE);
    endtask

    // acq is released one cycle after the pulse, while ready is low again
    task automatic run_command(input cmd_t c, input int num);
        line_t      rline_d;
        line_t      rline_i;
        line_t      rline_i2;
        arb_state_e exp_order[$];
        served_q.delete();
        case (c.cmd)
            "W": begin
                @(posedge clk);
                #1;
                d_acq = 1'b1;
                dcache_request(MEM_WRITE, c.d_addr, c.wline, rline_d);
                @(posedge clk);
                #1;
                d_acq = 1'b0;
                model_q[line_index(c.d_addr)] = c.wline;
            end
            "R": begin
                match_model(c.d_addr, c.exp_d, num);
                @(posedge clk);
                #1;
                d_acq = 1'b1;
                dcache_request(MEM_READ, c.d_addr, '0, rline_d);
                @(posedge clk);
                #1;
                d_acq = 1'b0;
                check_line("rdata_o (dcache)", rline_d, c.exp_d);
            end
            "I": begin
                match_model(c.i_addr, c.exp_i, num);
                @(posedge clk);
                #1;
                i_acq = 1'b1;
                icache_request(c.i_addr, rline_i);
                @(posedge clk);
                #1;
                i_acq = 1'b0;
                check_line("rdata_o (icache)", rline_i, c.exp_i);
            end
            "B": begin
                match_model(c.d_addr, c.exp_d, num);
                match_model(c.i_addr, c.exp_i, num);
                @(posedge clk);
                #1;
                d_acq = 1'b1;   // same cycle on both ports
                i_acq = 1'b1;
                fork
                    begin
                        dcache_request(MEM_READ, c.d_addr, '0, rline_d);
                        @(posedge clk);
                        #1;
                        d_acq = 1'b0;
                    end
                    begin
                        icache_request(c.i_addr, rline_i);
                        @(posedge clk);
                        #1;
                        i_acq = 1'b0;
                    end
                join
                check_line("rdata_o (dcache)", rline_d, c.exp_d);
                check_line("rdata_o (icache)", rline_i, c.exp_i);
                exp_order.push_back(ARB_DCACHE);   // dcache wins the tie
                exp_order.push_back(ARB_ICACHE);
                check_service(exp_order);
            end
            "H": begin
                match_model(c.d_addr, c.exp_d, num);
                match_model(c.i_addr, c.exp_i, num);
                @(posedge clk);
                #1;
                i_acq = 1'b1;
                fork
                    begin
                        icache_request(c.i_addr, rline_i);
                        icache_request(c.i_addr, rline_i2);   // acq still held
                        @(posedge clk);
                        #1;
                        i_acq = 1'b0;
                    end
                    begin
                        repeat (3) @(posedge clk);   // icache owns the port by now
                        #1;
                        d_acq = 1'b1;
                        dcache_request(MEM_READ, c.d_addr, '0, rline_d);
                        @(posedge clk);
                        #1;
                        d_acq = 1'b0;
                    end
                join
                check_line("rdata_o (icache first)", rline_i, c.exp_i);
                check_line("rdata_o (icache second)", rline_i2, c.exp_i);
                check_line("rdata_o (dcache)", rline_d, c.exp_d);
                exp_order.push_back(ARB_ICACHE);
                exp_order.push_back(ARB_ICACHE);
                exp_order.push_back(ARB_DCACHE);   // only after icache lets go
                check_service(exp_order);
            end
            default: begin
                abort_run($sformatf("unknown command %c in testdata command %0d", c.cmd, num));
            end
        endcase
    endtask

    initial begin
        rst   = 1'b1;
        i_acq = 1'b0;
        d_acq = 1'b0;
        i_req = '0;
        d_req = '0;
        foreach (model_q[k]) begin
            model_q[k] = '0;   // RAM starts zeroed
        end
        load_commands();
        cycle_limit = CYCLES_PER_CMD * cmd_q.size() + SETUP_CYCLES;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        // no acq yet so both ready outputs stay low
        repeat (4) begin
            @(posedge clk);
            #1;
            check_ready("i_ready_o", i_ready, 1'b0);
            check_ready("d_ready_o", d_ready, 1'b0);
        end
        foreach (cmd_q[k]) begin
            run_command(cmd_q[k], k + 1);
        end
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- test/mem_subsys_testdata.txt
# cmd d_addr i_addr wline exp_d exp_i in hex with 0 in unused fields
# W dcache write  R dcache read  I icache read  B both acq at once  H icache holds two reads
# reads of lines never written
R 40 0 0 0 0
I 0 50 0 0 0
R 7f0 0 0 0 0
# write then read back with neighbours untouched
W 40 0 1111222233334444aaaabbbbccccdddd 0 0
R 40 0 0 1111222233334444aaaabbbbccccdddd 0
R 50 0 0 0 0
R 30 0 0 0 0
W 50 0 5555666677778888eeeeffff00001111 0 0
R 40 0 0 1111222233334444aaaabbbbccccdddd 0
R 50 0 0 5555666677778888eeeeffff00001111 0
# icache sees dcache writes and addresses 0x800 apart alias
I 0 40 0 0 1111222233334444aaaabbbbccccdddd
I 0 840 0 0 1111222233334444aaaabbbbccccdddd
W 1050 0 0123456789abcdeffedcba9876543210 0 0
R 50 0 0 0123456789abcdeffedcba9876543210 0
I 0 858 0 0 0123456789abcdeffedcba9876543210
W 7f0 0 deadbeefcafef00d0badc0de12345678 0 0
R ff0 0 0 deadbeefcafef00d0badc0de12345678 0
# both ports at once so dcache goes first
B 40 50 0 1111222233334444aaaabbbbccccdddd 0123456789abcdeffedcba9876543210
B 7f0 840 0 deadbeefcafef00d0badc0de12345678 1111222233334444aaaabbbbccccdddd
# icache keeps the port across two reads
W 60 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 0 0
H 60 40 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1111222233334444aaaabbbbccccdddd
H 50 7f0 0 0123456789abcdeffedcba9876543210 deadbeefcafef00d0badc0de12345678
# overwrite and mixed traffic
W 40 0 00000000000000010000000000000002 0 0
I 0 40 0 0 00000000000000010000000000000002
R 840 0 0 00000000000000010000000000000002 0
B 0 60 0 0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0
W 0 0 ffffffffffffffff0000000000000000 0 0
H 0 0 0 ffffffffffffffff0000000000000000 ffffffffffffffff0000000000000000
R 808 0 0 ffffffffffffffff0000000000000000 0
I 0 1800 0 0 ffffffffffffffff0000000000000000
